//--- logic/dbg_biu_consts.svh
/*
 * Widths and AHB-Lite codes for the debug bus interface unit.
 * The data path is fixed at 32 bits and only single transfers exist.
 */

`ifndef DBG_BIU_CONSTS_SVH
`define DBG_BIU_CONSTS_SVH

// Bus widths
`define DBG_ADDR_W 32
`define DBG_DATA_W 32

// Transfer types in use
`define HTRANS_IDLE   2'b00
`define HTRANS_NONSEQ 2'b10

// Transfer sizes in use
`define HSIZE_BYTE  3'b000
`define HSIZE_HWORD 3'b001
`define HSIZE_WORD  3'b010

// Slave response
`define HRESP_OKAY  1'b0
`define HRESP_ERROR 1'b1

// Address bit that selects the erroring region of the memory model
`define DBG_ERR_BASE 12

`endif

//--- logic/dbg_biu_pkg.sv
/*
 * Types shared by the debug bus interface unit and its testbench.
 * Word size codes other than 1, 2 and 4 act as a full word.
 */

`include "dbg_biu_consts.svh"

package dbg_biu_pkg;

  // Debug word size code
  // 1 selects a byte, 2 a halfword, 4 a word
  typedef logic [3:0] word_size_t;

  // AHB transfer type, see HTRANS_* macros
  typedef logic [1:0] htrans_t;

  // AHB transfer size, see HSIZE_* macros
  typedef logic [2:0] hsize_t;

  // One AHB data word seen two ways
  // Lane 0 is always bits 7:0 or 15:0
  // Endianness only decides which lane an address picks
  typedef union packed {
    logic [`DBG_DATA_W/8-1:0][7:0]   bytes;
    logic [`DBG_DATA_W/16-1:0][15:0] halves;
  } ahb_data_u;

endpackage

//--- logic/dbg_reset_sync.sv
/*
 * Reset synchronizer, one per clock domain.
 * Assertion is immediate, release comes after two edges of clk.
 */

module dbg_reset_sync (
  input  logic clk,
  input  logic ahb_rstn,
  output logic rstn_sync
);

  // Shift register that fills with ones once reset is gone
  logic [1:0] sync_q;

  always_ff @(posedge clk or negedge ahb_rstn) begin
    if (!ahb_rstn) begin
      sync_q <= 2'b00;
    end else begin
      sync_q <= {sync_q[0], 1'b1};
    end
  end

  // Last stage drives the domain reset
  assign rstn_sync = sync_q[1];

endmodule

//--- logic/dbg_toggle_sync.sv
/*
 * Carries an active-toggle event into the clk domain.
 * The source may flip at most once per two destination cycles.
 * The pulse is combinational from the flops and lasts one cycle.
 */

module dbg_toggle_sync (
  input  logic clk,
  input  logic rstn,
  input  logic toggle_in,
  output logic pulse
);

  // Two synchronizing stages and a delayed copy
  logic sync1_q;
  logic sync2_q;
  logic sync2_dly_q;

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      sync1_q     <= 1'b0;
      sync2_q     <= 1'b0;
      sync2_dly_q <= 1'b0;
    end else begin
      sync1_q     <= toggle_in;
      sync2_q     <= sync1_q;
      sync2_dly_q <= sync2_q;
    end
  end

  // Any change of the settled level is one event
  assign pulse = sync2_q ^ sync2_dly_q;

endmodule

//--- logic/dbg_biu_request.sv
/*
 * Debug clock side of the bus interface unit.
 * Registered request fields hold until the next accepted strobe and are read
 * quasi-statically by the HCLK side. Strobes while biu_rdy is low are dropped.
 */

`include "dbg_biu_consts.svh"

module dbg_biu_request (
  input  logic                       tck,
  input  logic                       rstn,
  input  logic                       biu_strb,
  input  logic                       biu_rw,
  input  logic [`DBG_ADDR_W-1:0]     biu_addr,
  input  logic [`DBG_DATA_W-1:0]     biu_di,
  input  dbg_biu_pkg::word_size_t    biu_word_size,
  input  logic                       done_toggle,
  output logic                       biu_rdy,
  output logic                       start_toggle,
  output logic [`DBG_ADDR_W-1:0]     haddr,
  output logic                       hwrite,
  output dbg_biu_pkg::hsize_t        hsize,
  output logic [`DBG_DATA_W-1:0]     hwdata,
  output dbg_biu_pkg::word_size_t    req_size
);

  ////////////////////////////////////////////////////////////////////////////
  // Handshake
  ////////////////////////////////////////////////////////////////////////////

  // Request taken on this edge
  logic accept;
  // One-cycle pulse when the HCLK side finishes
  logic done_pulse;

  assign accept = biu_strb & biu_rdy;

  // Done toggle from the HCLK domain
  dbg_toggle_sync done_sync (
    .clk       (tck),
    .rstn      (rstn),
    .toggle_in (done_toggle),
    .pulse     (done_pulse)
  );

  // Ready is high out of reset
  // Cleared on acceptance and set again by the done event
  always_ff @(posedge tck or negedge rstn) begin
    if (!rstn) begin
      biu_rdy      <= 1'b1;
      start_toggle <= 1'b0;
    end else if (accept) begin
      biu_rdy      <= 1'b0;
      // Flip once per request, seen by the HCLK side as one start
      start_toggle <= ~start_toggle;
    end else if (done_pulse) begin
      biu_rdy <= 1'b1;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Request registers
  ////////////////////////////////////////////////////////////////////////////

  // Payload captured on acceptance only
  always_ff @(posedge tck) begin
    if (accept) begin
      haddr    <= biu_addr;
      hwrite   <= ~biu_rw;
      req_size <= biu_word_size;

      // Size code and lane replication
      // The slave picks the lane from the address
      case (biu_word_size)
        4'd1: begin
          hsize  <= `HSIZE_BYTE;
          hwdata <= {4{biu_di[7:0]}};
        end
        4'd2: begin
          hsize  <= `HSIZE_HWORD;
          hwdata <= {2{biu_di[15:0]}};
        end
        default: begin
          // Word and any unknown code
          hsize  <= `HSIZE_WORD;
          hwdata <= biu_di;
        end
      endcase
    end
  end

endmodule

//--- logic/dbg_read_lane_extract.sv
/*
 * Right-aligns the addressed byte or halfword of an AHB read word.
 * LITTLE_ENDIAN = 0 mirrors the lane order. Words pass through unchanged.
 */

`include "dbg_biu_consts.svh"

module dbg_read_lane_extract #(
  parameter bit LITTLE_ENDIAN = 1'b1
) (
  input  dbg_biu_pkg::ahb_data_u   rdata,
  input  logic [1:0]               addr_low,
  input  dbg_biu_pkg::word_size_t  req_size,
  output logic [`DBG_DATA_W-1:0]   rdata_aligned
);

  // Lane numbers after the endianness mapping
  logic [1:0] byte_lane;
  logic       half_lane;

  // Big endian puts address 0 in the top lane
  assign byte_lane = LITTLE_ENDIAN ? addr_low : ~addr_low;
  assign half_lane = LITTLE_ENDIAN ? addr_low[1] : ~addr_low[1];

  always_comb begin
    case (req_size)
      4'd1: begin
        // Byte, zero extended
        rdata_aligned = {24'h0, rdata.bytes[byte_lane]};
      end
      4'd2: begin
        // Halfword, addr_low[0] is ignored
        rdata_aligned = {16'h0, rdata.halves[half_lane]};
      end
      default: begin
        rdata_aligned = rdata;
      end
    endcase
  end

endmodule

//--- logic/dbg_biu_ahb_master.sv
/*
 * HCLK side of the bus interface unit, one single transfer at a time.
 * Address, size and request fields come quasi-static from the debug side.
 * biu_do and biu_err change only on the acknowledge edge.
 */

`include "dbg_biu_consts.svh"

module dbg_biu_ahb_master #(
  parameter bit LITTLE_ENDIAN = 1'b1
) (
  input  logic                       HCLK,
  input  logic                       rstn,
  input  logic                       start_toggle,
  input  logic [1:0]                 haddr_low,
  input  dbg_biu_pkg::word_size_t    req_size,
  input  logic [`DBG_DATA_W-1:0]     hrdata,
  input  logic                       hready,
  input  logic                       hresp,
  output dbg_biu_pkg::htrans_t       htrans,
  output logic [`DBG_DATA_W-1:0]     biu_do,
  output logic                       biu_err,
  output logic                       done_toggle
);

  ////////////////////////////////////////////////////////////////////////////
  // Start event
  ////////////////////////////////////////////////////////////////////////////

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_ADDR,
    ST_DATA
  } state_t;

  state_t state;

  logic start_pulse;
  // Start seen while busy, kept for the next idle cycle
  logic start_hold;
  logic start_req;
  // Data phase completes on this edge
  logic ack;
  logic [`DBG_DATA_W-1:0] rdata_aligned;

  dbg_toggle_sync start_sync (
    .clk       (HCLK),
    .rstn      (rstn),
    .toggle_in (start_toggle),
    .pulse     (start_pulse)
  );

  assign start_req = start_pulse | start_hold;
  assign ack       = hready & (state == ST_DATA);

  // Cleared whenever the machine is idle, since it launches from there
  always_ff @(posedge HCLK or negedge rstn) begin
    if (!rstn) begin
      start_hold <= 1'b0;
    end else if (state == ST_IDLE) begin
      start_hold <= 1'b0;
    end else if (start_pulse) begin
      start_hold <= 1'b1;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Address and data phase FSM
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge HCLK or negedge rstn) begin
    if (!rstn) begin
      state  <= ST_IDLE;
      htrans <= `HTRANS_IDLE;
    end else begin
      case (state)
        ST_IDLE: begin
          if (start_req) begin
            state  <= ST_ADDR;
            htrans <= `HTRANS_NONSEQ;
          end
        end
        ST_ADDR: begin
          // NONSEQ lasts exactly one cycle
          state  <= ST_DATA;
          htrans <= `HTRANS_IDLE;
        end
        ST_DATA: begin
          // Wait states only stretch this phase
          if (hready) begin
            state <= ST_IDLE;
          end
        end
        default: begin
          state  <= ST_IDLE;
          htrans <= `HTRANS_IDLE;
        end
      endcase
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Response capture
  ////////////////////////////////////////////////////////////////////////////

  dbg_read_lane_extract #(
    .LITTLE_ENDIAN (LITTLE_ENDIAN)
  ) lane_extract (
    .rdata         (hrdata),
    .addr_low      (haddr_low),
    .req_size      (req_size),
    .rdata_aligned (rdata_aligned)
  );

  // Read data register, also loaded on writes
  always_ff @(posedge HCLK) begin
    if (ack) begin
      biu_do <= rdata_aligned;
    end
  end

  // Error flag and done event back to tck
  always_ff @(posedge HCLK or negedge rstn) begin
    if (!rstn) begin
      biu_err     <= 1'b0;
      done_toggle <= 1'b0;
    end else if (ack) begin
      biu_err     <= (hresp == `HRESP_ERROR);
      done_toggle <= ~done_toggle;
    end
  end

endmodule

//--- logic/dbg_biu.sv
/*
 * Debug bus interface unit, single AHB-Lite transfers from the tck domain.
 * hsel, hburst, hprot and hmastlock are tied by the fabric.
 * Both domains reset from ahb_rstn with a local synchronized release.
 */

`include "dbg_biu_consts.svh"

module dbg_biu #(
  parameter bit LITTLE_ENDIAN = 1'b1
) (
  input  logic                       tck,
  input  logic                       HCLK,
  input  logic                       ahb_rstn,
  // Debug transport side
  input  logic                       biu_strb,
  input  logic                       biu_rw,
  input  logic [`DBG_ADDR_W-1:0]     biu_addr,
  input  logic [`DBG_DATA_W-1:0]     biu_di,
  input  dbg_biu_pkg::word_size_t    biu_word_size,
  output logic [`DBG_DATA_W-1:0]     biu_do,
  output logic                       biu_rdy,
  output logic                       biu_err,
  // AHB-Lite master side
  output logic [`DBG_ADDR_W-1:0]     haddr,
  output logic                       hwrite,
  output dbg_biu_pkg::hsize_t        hsize,
  output logic [`DBG_DATA_W-1:0]     hwdata,
  output dbg_biu_pkg::htrans_t       htrans,
  input  logic [`DBG_DATA_W-1:0]     hrdata,
  input  logic                       hready,
  input  logic                       hresp
);

  import dbg_biu_pkg::*;

  // Per domain resets
  logic rstn_tck;
  logic rstn_hclk;

  // Cross domain toggles
  logic start_toggle;
  logic done_toggle;

  // Word size of the request in flight
  word_size_t req_size;

  ////////////////////////////////////////////////////////////////////////////
  // Reset synchronizers
  ////////////////////////////////////////////////////////////////////////////

  dbg_reset_sync tck_rst_sync (
    .clk       (tck),
    .ahb_rstn  (ahb_rstn),
    .rstn_sync (rstn_tck)
  );

  dbg_reset_sync hclk_rst_sync (
    .clk       (HCLK),
    .ahb_rstn  (ahb_rstn),
    .rstn_sync (rstn_hclk)
  );

  ////////////////////////////////////////////////////////////////////////////
  // Domains
  ////////////////////////////////////////////////////////////////////////////

  dbg_biu_request request (
    .tck           (tck),
    .rstn          (rstn_tck),
    .biu_strb      (biu_strb),
    .biu_rw        (biu_rw),
    .biu_addr      (biu_addr),
    .biu_di        (biu_di),
    .biu_word_size (biu_word_size),
    .done_toggle   (done_toggle),
    .biu_rdy       (biu_rdy),
    .start_toggle  (start_toggle),
    .haddr         (haddr),
    .hwrite        (hwrite),
    .hsize         (hsize),
    .hwdata        (hwdata),
    .req_size      (req_size)
  );

  // Lane select uses only the low address bits
  dbg_biu_ahb_master #(
    .LITTLE_ENDIAN (LITTLE_ENDIAN)
  ) ahb_master (
    .HCLK         (HCLK),
    .rstn         (rstn_hclk),
    .start_toggle (start_toggle),
    .haddr_low    (haddr[1:0]),
    .req_size     (req_size),
    .hrdata       (hrdata),
    .hready       (hready),
    .hresp        (hresp),
    .htrans       (htrans),
    .biu_do       (biu_do),
    .biu_err      (biu_err),
    .done_toggle  (done_toggle)
  );

endmodule

//--- verif/dbg_biu_ahb_mem.sv
/*
 * AHB-Lite slave memory of 64 words, one transfer at a time, no pipelining.
 * Byte lanes are stored little-endian. Addresses with the error bit set get a
 * two-cycle ERROR response after their wait states, and writes there are dropped.
 */

`include "dbg_biu_consts.svh"

module dbg_biu_ahb_mem (
  input  logic                       HCLK,
  input  logic                       rstn,
  input  logic [`DBG_ADDR_W-1:0]     haddr,
  input  logic                       hwrite,
  input  dbg_biu_pkg::hsize_t        hsize,
  input  logic [`DBG_DATA_W-1:0]     hwdata,
  input  dbg_biu_pkg::htrans_t       htrans,
  output logic [`DBG_DATA_W-1:0]     hrdata,
  output logic                       hready,
  output logic                       hresp
);

  timeunit 1ns;
  timeprecision 1ps;

  import dbg_biu_pkg::*;

  ahb_data_u mem [64];

  // Data phase state, captured in the address phase
  logic        busy;
  logic [31:0] a_addr;
  logic        a_write;
  hsize_t      a_size;
  logic        a_err;
  logic [5:0]  idx;
  // Wait states still to go, then the second ERROR cycle
  logic [1:0]  wait_left;
  logic        err_last;

  logic [31:0] lfsr;
  logic [31:0] lfsr_a;
  logic [31:0] lfsr_b;
  ahb_data_u   wd;
  ahb_data_u   rd_word;

  // Fibonacci LFSR, taps 32 22 2 1, new bit enters at bit 0
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  // Fill depends on every word address
  initial begin
    for (int i = 0; i < 64; i++) begin
      mem[i[5:0]] = 32'h9e3779b9 * (i + 1);
    end
  end

  // Two steps give the two bits of the wait count
  assign lfsr_a  = lfsr_next(lfsr);
  assign lfsr_b  = lfsr_next(lfsr_a);
  assign idx     = a_addr[7:2];
  assign wd      = hwdata;
  assign rd_word = mem[idx];

  assign hresp  = busy & a_err & (wait_left == 2'd0);
  assign hready = ~busy | ((wait_left == 2'd0) & (~a_err | err_last));
  assign hrdata = busy ? rd_word : '0;

  always @(posedge HCLK or negedge rstn) begin
    if (!rstn) begin
      busy      <= 1'b0;
      a_addr    <= '0;
      a_write   <= 1'b0;
      a_size    <= `HSIZE_WORD;
      a_err     <= 1'b0;
      wait_left <= 2'd0;
      err_last  <= 1'b0;
      lfsr      <= 32'h14bb;
    end else begin
      // Data phase ends on this edge
      if (busy && hready) begin
        busy <= 1'b0;
        if (a_write && !a_err) begin
          case (a_size)
            `HSIZE_BYTE:  mem[idx].bytes[a_addr[1:0]] <= wd.bytes[a_addr[1:0]];
            `HSIZE_HWORD: mem[idx].halves[a_addr[1]] <= wd.halves[a_addr[1]];
            default:      mem[idx] <= wd;
          endcase
        end
      end
      if (hready && htrans == `HTRANS_NONSEQ) begin
        busy      <= 1'b1;
        a_addr    <= haddr;
        a_write   <= hwrite;
        a_size    <= hsize;
        a_err     <= haddr[`DBG_ERR_BASE];
        wait_left <= {lfsr_a[0], lfsr_b[0]};
        err_last  <= 1'b0;
        lfsr      <= lfsr_b;
      end else if (busy && !hready) begin
        if (wait_left != 2'd0) begin
          wait_left <= wait_left - 2'd1;
        end else begin
          err_last <= 1'b1;
        end
      end
    end
  end

endmodule

//--- verif/dbg_biu_sva.sv
/*
 * Protocol checks bound into the unit top, where both domains are visible.
 * Assumes the slave lowers hready only during this master's data phase.
 */

`include "dbg_biu_consts.svh"

module dbg_biu_sva (
  input logic                  HCLK,
  input logic                  rstn_hclk,
  input logic                  tck,
  input logic                  rstn_tck,
  input dbg_biu_pkg::htrans_t  htrans,
  input logic                  hready,
  input logic                  biu_strb,
  input logic                  biu_rdy
);

  timeunit 1ns;
  timeprecision 1ps;

  // Address phase is a single cycle
  nonseq_one_cycle: assert property (@(posedge HCLK) disable iff (!rstn_hclk)
    (htrans == `HTRANS_NONSEQ) |=> (htrans == `HTRANS_IDLE))
    else $error("htrans stayed NONSEQ for more than one cycle");

  // Nothing new is issued while the slave stretches the data phase
  idle_while_waiting: assert property (@(posedge HCLK) disable iff (!rstn_hclk)
    !hready |-> (htrans == `HTRANS_IDLE))
    else $error("htrans not IDLE while hready is low");

  // Accepted request drops ready on the next edge
  rdy_falls: assert property (@(posedge tck) disable iff (!rstn_tck)
    (biu_strb && biu_rdy) |=> !biu_rdy)
    else $error("biu_rdy did not fall after an accepted strobe");

endmodule

bind dbg_biu dbg_biu_sva protocol_checks (
  .HCLK      (HCLK),
  .rstn_hclk (rstn_hclk),
  .tck       (tck),
  .rstn_tck  (rstn_tck),
  .htrans    (htrans),
  .hready    (hready),
  .biu_strb  (biu_strb),
  .biu_rdy   (biu_rdy)
);

//--- verif/dbg_biu_tb.sv
/*
 * Testbench for the debug bus interface unit with an AHB-Lite memory model.
 * tck runs at 26 ns, HCLK at 10 ns, lane order little-endian.
 * Expected results come from a shadow copy of the memory model.
 */

`include "dbg_biu_consts.svh"

module dbg_biu_tb;

  timeunit 1ns;
  timeprecision 1ps;

  import dbg_biu_pkg::*;

  localparam bit LITTLE_ENDIAN = 1'b1;
  // Bound on tck cycles for any wait
  localparam int TIMEOUT_CYC = 100;

  logic        tck;
  logic        HCLK;
  logic        ahb_rstn;
  logic        biu_strb;
  logic        biu_rw;
  logic [31:0] biu_addr;
  logic [31:0] biu_di;
  word_size_t  biu_word_size;
  logic [31:0] biu_do;
  logic        biu_rdy;
  logic        biu_err;
  logic [31:0] haddr;
  logic        hwrite;
  hsize_t      hsize;
  logic [31:0] hwdata;
  htrans_t     htrans;
  logic [31:0] hrdata;
  logic        hready;
  logic        hresp;

  ahb_data_u   shadow [64];
  // Request in flight and its expected {biu_err, biu_do}
  logic        cur_rw;
  logic [31:0] cur_addr;
  logic [31:0] cur_data;
  word_size_t  cur_size;
  logic [32:0] cur_expect;
  int          issued = 0;
  int          compared = 0;
  int          cmp_errs = 0;
  int          seq_errs = 0;
  bit          timed_out = 1'b0;

  dbg_biu #(
    .LITTLE_ENDIAN (LITTLE_ENDIAN)
  ) UUT (
    .tck           (tck),
    .HCLK          (HCLK),
    .ahb_rstn      (ahb_rstn),
    .biu_strb      (biu_strb),
    .biu_rw        (biu_rw),
    .biu_addr      (biu_addr),
    .biu_di        (biu_di),
    .biu_word_size (biu_word_size),
    .biu_do        (biu_do),
    .biu_rdy       (biu_rdy),
    .biu_err       (biu_err),
    .haddr         (haddr),
    .hwrite        (hwrite),
    .hsize         (hsize),
    .hwdata        (hwdata),
    .htrans        (htrans),
    .hrdata        (hrdata),
    .hready        (hready),
    .hresp         (hresp)
  );

  dbg_biu_ahb_mem mem_model (
    .HCLK   (HCLK),
    .rstn   (ahb_rstn),
    .haddr  (haddr),
    .hwrite (hwrite),
    .hsize  (hsize),
    .hwdata (hwdata),
    .htrans (htrans),
    .hrdata (hrdata),
    .hready (hready),
    .hresp  (hresp)
  );

  initial begin
    HCLK = 1'b0;
    forever #5 HCLK = ~HCLK;
  end

  initial begin
    tck = 1'b0;
    forever #13 tck = ~tck;
  end

  ////////////////////////////////////////////////////////////////////////////
  // Reference model
  ////////////////////////////////////////////////////////////////////////////

  // Zero-extended lane, lane 0 at address 0 when little-endian
  function automatic logic [32:0] expect_result(input logic [31:0] addr,
                                                input word_size_t size);
    ahb_data_u   mem_word;
    logic [1:0]  lane;
    logic [31:0] data;
    mem_word = shadow[addr[7:2]];
    lane = LITTLE_ENDIAN ? addr[1:0] : ~addr[1:0];
    case (size)
      4'd1:    data = {24'h0, mem_word.bytes[lane]};
      4'd2:    data = {16'h0, mem_word.halves[lane[1]]};
      default: data = mem_word;
    endcase
    return {addr[`DBG_ERR_BASE], data};
  endfunction

  // Memory stores the lanes picked by address, little-endian
  task automatic shadow_write(input logic [31:0] addr, input logic [31:0] data,
                              input word_size_t size);
    case (size)
      4'd1:    shadow[addr[7:2]].bytes[addr[1:0]] = data[7:0];
      4'd2:    shadow[addr[7:2]].halves[addr[1]] = data[15:0];
      default: shadow[addr[7:2]] = data;
    endcase
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Driver
  ////////////////////////////////////////////////////////////////////////////

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    assert (got === exp) else begin
      seq_errs++;
      $display("ERROR %s: got %h, expected %h", name, got, exp);
    end
  endtask

  task automatic wait_ready();
    int n;
    n = 0;
    while (!biu_rdy && n < TIMEOUT_CYC) begin
      @(posedge tck);
      #1;
      n++;
    end
    if (!biu_rdy) begin
      seq_errs++;
      timed_out = 1'b1;
      $display("Timeout: biu_rdy did not rise within %0d tck cycles", TIMEOUT_CYC);
    end
  endtask

  // Strobe held for one edge, ends 1 ns after the accepting edge
  task automatic start_access(input logic rw, input logic [31:0] addr,
                              input logic [31:0] data, input word_size_t size);
    wait_ready();
    if (!timed_out) begin
      cur_rw = rw;
      cur_addr = addr;
      cur_data = data;
      cur_size = size;
      cur_expect = expect_result(addr, size);
      issued++;
      biu_rw = rw;
      biu_addr = addr;
      biu_di = data;
      biu_word_size = size;
      biu_strb = 1'b1;
      @(posedge tck);
      #1;
      biu_strb = 1'b0;
    end
  endtask

  // Error region writes never reach memory
  task automatic finish_access();
    wait_ready();
    if (!timed_out && !cur_rw && !cur_expect[32]) begin
      shadow_write(cur_addr, cur_data, cur_size);
    end
  endtask

  task automatic access(input logic rw, input logic [31:0] addr,
                        input logic [31:0] data, input word_size_t size);
    start_access(rw, addr, data, size);
    finish_access();
  endtask

  // Response check on every completion
  always @(posedge biu_rdy) begin
    if (compared < issued) begin
      compared++;
      assert (biu_err === cur_expect[32]) else begin
        cmp_errs++;
        $display("ERROR biu_err @%h: got %h, expected %h", cur_addr, biu_err, cur_expect[32]);
      end
      if (cur_rw && !cur_expect[32]) begin
        assert (biu_do === cur_expect[31:0]) else begin
          cmp_errs++;
          $display("ERROR biu_do @%h: got %h, expected %h", cur_addr, biu_do,
                   cur_expect[31:0]);
        end
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Sequence
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    word_size_t  sz;
    logic [31:0] addr;
    logic [31:0] base;
    ahb_rstn = 1'b0;
    biu_strb = 1'b0;
    biu_rw = 1'b0;
    biu_addr = '0;
    biu_di = '0;
    biu_word_size = 4'd4;
    for (int i = 0; i < 64; i++) begin
      shadow[i[5:0]] = 32'h9e3779b9 * (i + 1);
    end
    repeat (4) @(posedge HCLK);
    #1;
    ahb_rstn = 1'b1;
    repeat (3) @(posedge tck);
    #1;

    // Idle state out of reset
    check_value("biu_rdy", 32'(biu_rdy), 32'h1);
    check_value("htrans", 32'(htrans), 32'(`HTRANS_IDLE));
    check_value("biu_err", 32'(biu_err), 32'h0);

    // Words written then read back
    for (int i = 0; i < 8; i++) begin
      access(1'b0, 32'h80 + 4 * i, 32'hc001_0000 + i * 32'h1111, 4'd4);
    end
    for (int i = 0; i < 8; i++) begin
      access(1'b1, 32'h80 + 4 * i, 32'h0, 4'd4);
    end

    // Every byte lane, then both halfwords
    for (int lane = 0; lane < 4; lane++) begin
      access(1'b0, 32'h20 + lane, 32'h11 * (lane + 1), 4'd1);
      access(1'b1, 32'h20, 32'h0, 4'd4);
    end
    for (int half = 0; half < 2; half++) begin
      access(1'b0, 32'h24 + 2 * half, 32'h1234_a5c3 + 32'h1111 * half, 4'd2);
      access(1'b1, 32'h24, 32'h0, 4'd4);
    end
    for (int a = 0; a < 4; a++) begin
      access(1'b1, 32'h20 + a, 32'h0, 4'd1);
      access(1'b1, 32'h24 + a, 32'h0, 4'd2);
    end
    // Unknown size code acts as a word
    access(1'b1, 32'h24, 32'h0, 4'd7);

    // Mixed sizes over scattered words, wait states from the model
    for (int i = 0; i < 24; i++) begin
      base = ((i * 29) % 64) * 4;
      case (i % 3)
        0: begin
          sz = 4'd1;
          addr = base + (i % 4);
        end
        1: begin
          sz = 4'd2;
          addr = base + (i % 2) * 2;
        end
        default: begin
          sz = 4'd4;
          addr = base;
        end
      endcase
      access(1'b0, addr, 32'h5a00_0000 ^ (i * 32'h0103_0507), sz);
      access(1'b1, addr, 32'h0, sz);
      access(1'b1, base, 32'h0, 4'd4);
    end

    // Error region, then an ordinary word on the same index
    access(1'b1, 32'h1010, 32'h0, 4'd4);
    access(1'b0, 32'h1010, 32'hdead_beef, 4'd4);
    access(1'b1, 32'h1012, 32'h0, 4'd2);
    access(1'b1, 32'h10, 32'h0, 4'd4);

    // Strobe while busy must be dropped
    start_access(1'b0, 32'h40, 32'h600d_0001, 4'd4);
    if (!timed_out) begin
      check_value("biu_rdy", 32'(biu_rdy), 32'h0);
      biu_di = 32'hbad0_0002;
      biu_strb = 1'b1;
      @(posedge tck);
      #1;
      biu_strb = 1'b0;
    end
    finish_access();
    access(1'b1, 32'h40, 32'h0, 4'd4);

    if (!timed_out) begin
      check_value("compare count", compared, issued);
    end
    $display("Error count: %0d in responses, %0d in sequence", cmp_errs, seq_errs);
    if (cmp_errs == 0 && seq_errs == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule

//--- build.f
+incdir+logic
logic/dbg_biu_pkg.sv
logic/dbg_reset_sync.sv
logic/dbg_toggle_sync.sv
logic/dbg_biu_request.sv
logic/dbg_read_lane_extract.sv
logic/dbg_biu_ahb_master.sv
logic/dbg_biu.sv
verif/dbg_biu_ahb_mem.sv
verif/dbg_biu_sva.sv
verif/dbg_biu_tb.sv

//--- run_sim.sh
#!/bin/sh
# Builds and runs the debug BIU testbench with Verilator.
# Exits non-zero on a build error, a crashed run or a reported failure.

cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir

verilator --binary --assert --timescale 1ns/1ps --top-module dbg_biu_tb \
  -f build.f --Mdir "$OBJ" -o dbg_biu_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

"./$OBJ/dbg_biu_sim" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "Done: errors found" "$LOG"; then
  exit 1
fi
exit 0
